// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// --------------------
	// Opcodes
	// --------------------
	localparam logic [3:0] OP_ADD = 4'b0000;
	localparam logic [3:0] OP_SUB = 4'b0001;
	localparam logic [3:0] OP_XOR = 4'b0010;
	localparam logic [3:0] OP_SLL = 4'b0100;
	localparam logic [3:0] OP_SRA = 4'b0101;
	localparam logic [3:0] OP_ROR = 4'b0110;
	localparam logic [3:0] OP_LHB = 4'b1010; // Load high byte
	localparam logic [3:0] OP_LLB = 4'b1011; // Load low byte
	localparam logic [3:0] OP_HLT = 4'b1111;

	// --------------------
	// Instruction word
	// --------------------
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt; // Shift amount for SLL/SRA/ROR
	} instr_rtype_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [7:0] imm8;
	} instr_itype_t;

	// Same 16 bits, two views
	typedef union packed {
		instr_rtype_t r;
		instr_itype_t i;
	} instr_t;

	// --------------------
	// Stage packets
	// --------------------
	typedef struct packed {
		logic        valid;
		logic        halt;   // HLT word
		logic [15:0] pc;
		instr_t      instr;
	} fetch_pkt_t;

	typedef struct packed {
		logic        valid;
		logic        halt;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  src_a;  // Source selects kept for forwarding
		logic [3:0]  src_b;
		logic [15:0] data_a;
		logic [15:0] data_b;
		logic [7:0]  imm;
		logic        rd_we;
	} issue_pkt_t;

	typedef struct packed {
		logic        valid;
		logic [3:0]  rd;
		logic [15:0] data;
	} wb_pkt_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [15:0]         imem_data,
	output logic [15:0]         imem_addr,
	output cpu_pkg::fetch_pkt_t fetch
);

	import cpu_pkg::*;

	logic [15:0] pc;
	logic        halted; // Set once the HLT word has gone out
	instr_t      word;
	logic        is_hlt;

	assign word   = imem_data;
	assign is_hlt = (word.r.opcode == OP_HLT);

	// --------------------
	// PC register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			if (is_hlt) begin
				halted <= 1'b1; // Freeze on the HLT address
			end else begin
				pc <= pc + 16'd2; // Next word
			end
		end
	end

	assign imem_addr = pc;

	// --------------------
	// Fetch packet
	// --------------------
	// Bubbles only once halted
	always_comb begin
		fetch.valid = !halted;
		fetch.halt  = !halted && is_hlt; // Marks the HLT word itself
		fetch.pc    = pc;
		fetch.instr = word;
	end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic             clk,
	input  logic             reset,
	input  logic [3:0]       rd_a_sel,
	input  logic [3:0]       rd_b_sel,
	output logic [15:0]      rd_a_data,
	output logic [15:0]      rd_b_data,
	input  cpu_pkg::wb_pkt_t wr
);

	import cpu_pkg::*;

	logic [15:0] regs [16];
	logic        wr_en;

	assign wr_en = wr.valid && (wr.rd != 4'd0); // r0 stays zero

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (wr_en) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// --------------------
	// Read ports
	// --------------------
	// Same-cycle write returns the new value
	always_comb begin
		if (wr_en && (wr.rd == rd_a_sel)) begin
			rd_a_data = wr.data;
		end else begin
			rd_a_data = regs[rd_a_sel];
		end
		if (wr_en && (wr.rd == rd_b_sel)) begin
			rd_b_data = wr.data;
		end else begin
			rd_b_data = regs[rd_b_sel];
		end
	end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                reset,
	input  cpu_pkg::fetch_pkt_t fetch,
	input  cpu_pkg::wb_pkt_t    wb,
	output cpu_pkg::issue_pkt_t issue
);

	import cpu_pkg::*;

	fetch_pkt_t  if_id;
	instr_t      word;
	logic [3:0]  op;
	logic        byte_load;
	logic        writes_reg;
	logic [3:0]  sel_a;
	logic [3:0]  sel_b;
	logic [15:0] data_a;
	logic [15:0] data_b;

	// --------------------
	// IF/ID register
	// --------------------
	always_ff @(posedge clk) begin
		if_id.pc    <= fetch.pc;
		if_id.instr <= fetch.instr;
		if (reset) begin
			if_id.valid <= 1'b0;
			if_id.halt  <= 1'b0;
		end else begin
			if_id.valid <= fetch.valid;
			if_id.halt  <= fetch.halt;
		end
	end

	// --------------------
	// Field decode
	// --------------------
	assign word      = if_id.instr;
	assign op        = word.r.opcode;
	assign byte_load = (op == OP_LHB) || (op == OP_LLB);

	// Byte loads merge into the old rd value
	assign sel_a = byte_load ? word.r.rd : word.r.rs;
	assign sel_b = word.r.rt; // Unused by shifts and byte loads

	always_comb begin
		case (op)
			OP_ADD, OP_SUB, OP_XOR: writes_reg = 1'b1;
			OP_SLL, OP_SRA, OP_ROR: writes_reg = 1'b1;
			OP_LHB, OP_LLB:         writes_reg = 1'b1;
			default:                writes_reg = 1'b0; // HLT and the rest retire as NOP
		endcase
	end

	register_file regfile_i (
		.clk       (clk),
		.reset     (reset),
		.rd_a_sel  (sel_a),
		.rd_b_sel  (sel_b),
		.rd_a_data (data_a),
		.rd_b_data (data_b),
		.wr        (wb)
	);

	// --------------------
	// ID/EX register
	// --------------------
	always_ff @(posedge clk) begin
		issue.op     <= op;
		issue.rd     <= word.r.rd;
		issue.src_a  <= sel_a;
		issue.src_b  <= sel_b;
		issue.data_a <= data_a;
		issue.data_b <= data_b;
		issue.imm    <= word.i.imm8;          // Low nibble doubles as shift amount
		issue.rd_we  <= writes_reg && (word.r.rd != 4'd0); // No r0 writeback
		if (reset) begin
			issue.valid <= 1'b0;
			issue.halt  <= 1'b0;
		end else begin
			issue.valid <= if_id.valid;
			issue.halt  <= if_id.valid && if_id.halt;
		end
	end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  logic [3:0]  op,
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  logic [7:0]  imm,
	output logic [15:0] result
);

	import cpu_pkg::*;

	logic [3:0]  shamt;
	logic [31:0] rot_word; // a twice for the rotate
	logic [31:0] rot_shifted;

	assign shamt       = imm[3:0];
	assign rot_word    = {a, a};
	assign rot_shifted = rot_word >> shamt;

	// --------------------
	// Result select
	// --------------------
	always_comb begin
		case (op)
			OP_ADD: begin
				result = a + b; // Wraps at 16 bits
			end
			OP_SUB: begin
				result = a - b;
			end
			OP_XOR: begin
				result = a ^ b;
			end
			OP_SLL: begin
				result = a << shamt;
			end
			OP_SRA: begin
				result = $signed(a) >>> shamt; // Sign fill
			end
			OP_ROR: begin
				result = rot_shifted[15:0];
			end
			OP_LLB: begin
				result = {a[15:8], imm}; // Keep high byte
			end
			OP_LHB: begin
				result = {imm, a[7:0]}; // Keep low byte
			end
			default: begin
				result = 16'h0000;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic                clk,
	input  logic                reset,
	input  cpu_pkg::issue_pkt_t issue,
	output cpu_pkg::wb_pkt_t    wb,
	output logic                hlt
);

	import cpu_pkg::*;

	logic        wb_live; // wb holds a real register write
	logic        fwd_a;
	logic        fwd_b;
	logic [15:0] op_a;
	logic [15:0] op_b;
	logic [15:0] result;

	// --------------------
	// Forwarding
	// --------------------
	// Covers the previous instruction only
	assign wb_live = wb.valid && (wb.rd != 4'd0);
	assign fwd_a   = wb_live && (wb.rd == issue.src_a);
	assign fwd_b   = wb_live && (wb.rd == issue.src_b);

	assign op_a = fwd_a ? wb.data : issue.data_a;
	assign op_b = fwd_b ? wb.data : issue.data_b;

	alu alu_i (
		.op     (issue.op),
		.a      (op_a),
		.b      (op_b),
		.imm    (issue.imm),
		.result (result)
	);

	// --------------------
	// Writeback register
	// --------------------
	always_ff @(posedge clk) begin
		wb.rd   <= issue.rd;
		wb.data <= result;
		if (reset) begin
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= issue.valid && issue.rd_we; // Bubbles and NOPs write nothing
		end
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			hlt <= 1'b0;
		end else if (issue.valid && issue.halt) begin
			hlt <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic             clk,
	input  logic             reset,
	output logic [15:0]      imem_addr,
	input  logic [15:0]      imem_data,
	output logic [15:0]      pc_out,
	output logic             hlt,
	output cpu_pkg::wb_pkt_t wb
);

	import cpu_pkg::*;

	fetch_pkt_t fetch; // IF -> ID
	issue_pkt_t issue; // ID -> EX

	// --------------------
	// Stages
	// --------------------
	fetch_unit #(
		.RESET_PC (RESET_PC)
	) fetch_i (
		.clk       (clk),
		.reset     (reset),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.fetch     (fetch)
	);

	decode_stage decode_i (
		.clk   (clk),
		.reset (reset),
		.fetch (fetch),
		.wb    (wb),    // Register file write port
		.issue (issue)
	);

	execute_stage execute_i (
		.clk   (clk),
		.reset (reset),
		.issue (issue),
		.wb    (wb),
		.hlt   (hlt)
	);

	assign pc_out = imem_addr; // PC seen from outside

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
	input logic             clk,
	input logic             reset,
	input logic [15:0]      pc_out,
	input logic             hlt,
	input cpu_pkg::wb_pkt_t wb
);

	int fail_count; // Failed assertions so far

	// --------------------
	// Pipeline invariants
	// --------------------
	no_r0_write: assert property (@(posedge clk) disable iff (reset)
		!(wb.valid && wb.rd == 4'd0))
		else begin
			fail_count++;
			$error("writeback valid with rd r0");
		end

	// Sticky halt
	hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
		else begin
			fail_count++;
			$error("hlt fell without reset");
		end

	pc_frozen: assert property (@(posedge clk) disable iff (reset) hlt |-> $stable(pc_out))
		else begin
			fail_count++;
			$error("pc moved while halted");
		end

endmodule

`default_nettype wire

// ==== test/cpu_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_monitor #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [15:0]      pc_out,
	input  logic             hlt,
	input  cpu_pkg::wb_pkt_t wb,
	output int               error_count,
	output int               pending
);

	import cpu_pkg::*;

	typedef struct packed {
		logic [3:0]  rd;
		logic [15:0] data;
		logic [15:0] cycle; // Cycle after reset where wb shows it
	} exp_write_t;

	exp_write_t exp_q [$];
	string      name_q [$];
	int         cycle;      // 0 is the first cycle out of reset
	int         halt_idx;
	bit         halt_known;

	task automatic expect_write(input string name, input logic [3:0] rd,
			input logic [15:0] data, input int at_cycle);
		exp_write_t entry;
		entry.rd    = rd;
		entry.data  = data;
		entry.cycle = 16'(at_cycle);
		exp_q.push_back(entry);
		name_q.push_back(name);
		pending = exp_q.size();
	endtask

	task automatic expect_halt(input int idx);
		halt_idx   = idx;
		halt_known = 1'b1;
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		error_count++;
	endtask

	// PC steps by 2 until the HLT word, then stays put
	function automatic logic [15:0] expected_pc(input int c);
		int taken;
		taken = c;
		if (halt_known && c > halt_idx) begin
			taken = halt_idx;
		end
		return RESET_PC + 16'(2 * taken);
	endfunction

	// --------------------
	// Writeback compare
	// --------------------
	task automatic check_write();
		exp_write_t want;
		string      name;
		if (exp_q.size() == 0) begin
			$display("ERROR: unexpected writeback to r%0d with data %h in cycle %0d",
				wb.rd, wb.data, cycle);
			error_count++;
		end else begin
			want    = exp_q.pop_front();
			name    = name_q.pop_front();
			pending = exp_q.size();
			if (wb.rd !== want.rd) report_mismatch({name, " rd"}, 16'(want.rd), 16'(wb.rd));
			if (wb.data !== want.data) report_mismatch({name, " data"}, want.data, wb.data);
			if (16'(cycle) !== want.cycle) report_mismatch({name, " cycle"}, want.cycle,
				16'(cycle));
		end
	endtask

	// Sampled mid-cycle, all DUT outputs settled
	always @(negedge clk) begin
		if (reset) begin
			cycle = 0;
		end else begin
			if (cycle == 0 && wb.valid !== 1'b0) begin
				report_mismatch("wb valid out of reset", 16'h0000, 16'(wb.valid));
			end
			if (pc_out !== expected_pc(cycle)) begin
				report_mismatch($sformatf("pc in cycle %0d", cycle), expected_pc(cycle), pc_out);
			end
			if (hlt !== (halt_known && cycle >= halt_idx + 3)) begin // Halt lands at n+3
				report_mismatch($sformatf("hlt in cycle %0d", cycle),
					16'(halt_known && cycle >= halt_idx + 3), 16'(hlt));
			end
			if (wb.valid === 1'b1) check_write();
			cycle = cycle + 1;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

	import cpu_pkg::*;

	localparam logic [15:0] RESET_PC      = 16'h0040;
	localparam int          NUM_STEPS     = 25;
	localparam logic [15:0] NOP_WORD      = 16'h3000; // Opcode 0011 lies outside the subset
	localparam int          WRITE_TIMEOUT = 100;
	localparam int          HALT_TIMEOUT  = 20;
	localparam int          SETTLE_CYCLES = 8;  // Quiet cycles watched after halt

	// One program word and the write it should cause
	typedef struct packed {
		logic [15:0] word;
		logic        we;
		logic [3:0]  rd;
		logic [15:0] data;
	} step_t;

	logic        clk = 1'b0;
	logic        reset;
	logic [15:0] imem_addr;
	logic [15:0] imem_data;
	logic [15:0] pc_out;
	logic        hlt;
	wb_pkt_t     wb;
	int          value_errors;   // From the monitor
	int          pending;        // Expected writes not seen yet
	int          timeout_errors;
	int          halt_idx;

	step_t steps [NUM_STEPS];
	string step_names [NUM_STEPS];

	// --------------------
	// DUT and watchers
	// --------------------
	cpu #(
		.RESET_PC (RESET_PC)
	) cpu_i (
		.clk       (clk),
		.reset     (reset),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.pc_out    (pc_out),
		.hlt       (hlt),
		.wb        (wb)
	);

	cpu_monitor #(
		.RESET_PC (RESET_PC)
	) mon_i (
		.clk         (clk),
		.reset       (reset),
		.pc_out      (pc_out),
		.hlt         (hlt),
		.wb          (wb),
		.error_count (value_errors),
		.pending     (pending)
	);

	bind cpu cpu_checker checker_i (
		.clk    (clk),
		.reset  (reset),
		.pc_out (pc_out),
		.hlt    (hlt),
		.wb     (wb)
	);

	always #4 clk = ~clk; // 8 ns period

	task automatic set_step(input int idx, input string name, input logic [15:0] word,
			input logic we, input logic [3:0] rd, input logic [15:0] data);
		steps[idx].word = word;
		steps[idx].we   = we;
		steps[idx].rd   = rd;
		steps[idx].data = data;
		step_names[idx] = name;
	endtask

	// --------------------
	// Program table
	// --------------------
	// Data worked out by hand from registers that start at zero
	task automatic load_program();
		set_step(0,  "llb r1",      16'hB134, 1'b1, 4'd1,  16'h0034);
		set_step(1,  "lhb r1 fwd",  16'hA112, 1'b1, 4'd1,  16'h1234); // Needs forwarding
		set_step(2,  "llb r2",      16'hB2F0, 1'b1, 4'd2,  16'h00F0);
		set_step(3,  "lhb r2 fwd",  16'hA2FF, 1'b1, 4'd2,  16'hFFF0);
		set_step(4,  "add wrap",    16'h0312, 1'b1, 4'd3,  16'h1224); // Carry out dropped
		set_step(5,  "sub wrap",    16'h1412, 1'b1, 4'd4,  16'h1244);
		set_step(6,  "xor dist2",   16'h2534, 1'b1, 4'd5,  16'h0060); // r3 via write-through
		set_step(7,  "add dist1",   16'h0655, 1'b1, 4'd6,  16'h00C0); // Both operands forwarded
		set_step(8,  "sub from r0", 16'h1701, 1'b1, 4'd7,  16'hEDCC);
		set_step(9,  "llb r8",      16'hB881, 1'b1, 4'd8,  16'h0081);
		set_step(10, "lhb r8",      16'hA880, 1'b1, 4'd8,  16'h8081);
		set_step(11, "sll 4",       16'h4984, 1'b1, 4'd9,  16'h0810);
		set_step(12, "sra 3 neg",   16'h5A83, 1'b1, 4'd10, 16'hF010); // Sign fill
		set_step(13, "ror 8",       16'h6B88, 1'b1, 4'd11, 16'h8180);
		set_step(14, "ror 4",       16'h6C14, 1'b1, 4'd12, 16'h4123);
		set_step(15, "sra 15 neg",  16'h5D2F, 1'b1, 4'd13, 16'hFFFF);
		set_step(16, "sra 1 pos",   16'h5E11, 1'b1, 4'd14, 16'h091A);
		set_step(17, "sll 15",      16'h4F8F, 1'b1, 4'd15, 16'h8000);
		set_step(18, "add to r0",   16'h0012, 1'b0, 4'd0,  16'h0000); // Dropped write
		set_step(19, "read r0",     16'h0301, 1'b1, 4'd3,  16'h1234);
		set_step(20, "xor r0 r0",   16'h2400, 1'b1, 4'd4,  16'h0000);
		set_step(21, "nop opcode",  16'h7123, 1'b0, 4'd0,  16'h0000);
		set_step(22, "ror 0",       16'h65F0, 1'b1, 4'd5,  16'h8000);
		set_step(23, "hlt",         16'hF000, 1'b0, 4'd0,  16'h0000);
		// Would write r1 if the PC ran past HLT
		set_step(24, "after hlt",   16'hB1AA, 1'b0, 4'd0,  16'h0000);
	endtask

	function automatic int find_halt();
		for (int k = 0; k < NUM_STEPS; k++) begin
			if (steps[k].word[15:12] == 4'hF) begin
				return k;
			end
		end
		return NUM_STEPS; // No HLT in the table
	endfunction

	// Instruction memory view of the table
	function automatic logic [15:0] word_at(input logic [15:0] addr);
		int idx;
		idx = (int'(addr) - int'(RESET_PC)) / 2;
		if (addr >= RESET_PC && addr[0] == 1'b0 && idx < NUM_STEPS) begin
			return steps[idx].word;
		end
		return NOP_WORD; // Also covers an unknown address
	endfunction

	// --------------------
	// Stimulus
	// --------------------
	task automatic run_cycle();
		@(posedge clk);
		#1;
		imem_data = word_at(imem_addr); // PC has settled by now
	endtask

	task automatic wait_for_writes();
		int waited;
		waited = 0;
		while (pending != 0 && waited < WRITE_TIMEOUT) begin
			run_cycle();
			waited++;
		end
		if (pending != 0) begin
			$display("ERROR: %0d expected writebacks did not appear within %0d cycles",
				pending, WRITE_TIMEOUT);
			timeout_errors++;
		end
	endtask

	task automatic wait_for_halt();
		int waited;
		waited = 0;
		while (hlt !== 1'b1 && waited < HALT_TIMEOUT) begin
			run_cycle();
			waited++;
		end
		if (hlt !== 1'b1) begin
			$display("ERROR: hlt did not rise within %0d cycles", HALT_TIMEOUT);
			timeout_errors++;
		end
	endtask

	initial begin
		reset          = 1'b1;
		imem_data      = NOP_WORD;
		timeout_errors = 0;
		load_program();
		halt_idx = find_halt();
		// Word fetched in cycle k shows its write in cycle k+3
		for (int k = 0; k < halt_idx; k++) begin
			if (steps[k].we) begin
				mon_i.expect_write(step_names[k], steps[k].rd, steps[k].data, k + 3);
			end
		end
		mon_i.expect_halt(halt_idx);
		for (int c = 0; c < 3; c++) begin
			run_cycle(); // Reset cycles
		end
		reset = 1'b0;
		wait_for_writes();
		wait_for_halt();
		for (int c = 0; c < SETTLE_CYCLES; c++) begin
			run_cycle(); // Nothing may move now
		end
		$display("Errors: %0d value, %0d timeout, %0d assertion", value_errors,
			timeout_errors, cpu_i.checker_i.fail_count);
		if (value_errors + timeout_errors + cpu_i.checker_i.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
src/cpu_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/cpu.sv
test/cpu_checker.sv
test/cpu_monitor.sv
test/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - files:
      - src/cpu_pkg.sv
      - src/fetch_unit.sv
      - src/register_file.sv
      - src/decode_stage.sv
      - src/alu.sv
      - src/execute_stage.sv
      - src/cpu.sv
  - target: test
    files:
      - test/cpu_checker.sv
      - test/cpu_monitor.sv
      - test/tb_cpu.sv
